// ==== rtl/me_defs.svh ====
`ifndef ME_DEFS_SVH
`define ME_DEFS_SVH

// Block geometry
`define ME_EDGE 8 // Rows and columns of the current block

// Horizontal search range
`define ME_CANDIDATES 16 // Candidate k uses window columns k..k+7
`define ME_WIN_COLS 24 // Last column is loaded but never compared

// Input beat counts
`define ME_CUR_BEATS 16 // Four pixels per beat
`define ME_REF_BEATS 24 // Eight pixels per beat

`endif

// ==== rtl/me_pkg.sv ====
package me_pkg;

`include "me_defs.svh"

    typedef logic [7:0] pixel_t; // One luma sample

    // Input beats, lowest byte holds the lowest column
    typedef logic [`ME_EDGE*`ME_EDGE*$bits(pixel_t)/`ME_CUR_BEATS-1:0] cur_beat_t;
    typedef logic [`ME_EDGE*`ME_WIN_COLS*$bits(pixel_t)/`ME_REF_BEATS-1:0] ref_beat_t;

    // Sum of one row of absolute differences
    typedef logic [$bits(pixel_t)+$clog2(`ME_EDGE)-1:0] psad_t;

    // Full candidate SAD, max 64 * 255
    typedef logic [$bits(pixel_t)+$clog2(`ME_EDGE*`ME_EDGE)-1:0] sad_t;

    typedef logic [$clog2(`ME_CANDIDATES)-1:0] cand_idx_t; // Horizontal offset

    typedef enum logic {
        scan_idle,
        scan_run
    } scan_state_t;

endpackage

// ==== rtl/me_ifs.sv ====
`include "me_defs.svh"

// Row partial sums of one candidate, sad_array to sad_adder
interface psad_if;
    logic                                 valid;
    me_pkg::cand_idx_t                    index;
    logic                                 last; // Final candidate of the block
    me_pkg::psad_t     [`ME_EDGE-1:0]     psad; // One entry per block row

    modport src (
        output valid,
        output index,
        output last,
        output psad
    );

    modport dst (
        input valid,
        input index,
        input last,
        input psad
    );
endinterface

// Complete candidate SAD, sad_adder to min_select
interface sad_if;
    logic              valid;
    me_pkg::cand_idx_t index;
    logic              last;
    me_pkg::sad_t      sad;

    modport src (output valid, output index, output last, output sad);
    modport dst (input valid, input index, input last, input sad);
endinterface

// ==== rtl/cur_buffer.sv ====
`include "me_defs.svh"

module cur_buffer (
    input  logic                                              clk,
    input  logic                                              rst,
    input  me_pkg::cur_beat_t                                 cur_in,
    input  logic                                              cur_valid,
    input  logic                                              blk_release,
    output logic                                              need_cur,
    output logic                                              full,
    output me_pkg::pixel_t [`ME_EDGE-1:0][`ME_EDGE-1:0]       cur_block
);

    localparam int PIX_W         = $bits(me_pkg::pixel_t);
    localparam int BEATS_PER_ROW = `ME_CUR_BEATS / `ME_EDGE; // Two beats per row
    localparam int PIX_PER_BEAT  = `ME_EDGE / BEATS_PER_ROW;
    localparam int CNT_W         = $clog2(`ME_CUR_BEATS);

    logic [CNT_W-1:0] beat_cnt;
    logic             take;

    assign need_cur = ~full;
    assign take     = cur_valid && need_cur; // Beats are dropped while full

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
            full     <= 1'b0;
        end else if (blk_release) begin
            beat_cnt <= '0; // Scan is done with this block
            full     <= 1'b0;
        end else if (take) begin
            if (beat_cnt == CNT_W'(`ME_CUR_BEATS - 1)) begin
                beat_cnt <= '0;
                full     <= 1'b1;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Beat n lands in row n/2, columns 4*(n%2) upward
    always_ff @(posedge clk) begin
        if (take) begin
            for (int p = 0; p < PIX_PER_BEAT; p++) begin
                cur_block[beat_cnt / BEATS_PER_ROW]
                         [(beat_cnt % BEATS_PER_ROW) * PIX_PER_BEAT + p]
                    <= cur_in[p*PIX_W +: PIX_W];
            end
        end
    end

endmodule

// ==== rtl/ref_window.sv ====
`include "me_defs.svh"

module ref_window (
    input  logic                                              clk,
    input  logic                                              rst,
    input  me_pkg::ref_beat_t                                 ref_in,
    input  logic                                              ref_valid,
    input  logic                                              blk_release,
    output logic                                              need_ref,
    output logic                                              full,
    output me_pkg::pixel_t [`ME_EDGE-1:0][`ME_WIN_COLS-1:0]   window
);

    localparam int PIX_W         = $bits(me_pkg::pixel_t);
    localparam int BEATS_PER_ROW = `ME_REF_BEATS / `ME_EDGE; // Three beats per row
    localparam int PIX_PER_BEAT  = `ME_WIN_COLS / BEATS_PER_ROW;
    localparam int CNT_W         = $clog2(`ME_REF_BEATS);
    localparam int ROW_W         = $clog2(`ME_EDGE);
    localparam int GRP_W         = $clog2(BEATS_PER_ROW);

    logic [CNT_W-1:0] beat_cnt;
    logic [ROW_W-1:0] row;
    logic [GRP_W-1:0] grp; // Column group inside the row
    logic             take;

    assign need_ref = ~full;
    assign take     = ref_valid && need_ref;

    // Beat m lands in row m/3, column group m%3
    assign row = ROW_W'(beat_cnt / CNT_W'(BEATS_PER_ROW));
    assign grp = GRP_W'(beat_cnt % CNT_W'(BEATS_PER_ROW));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            beat_cnt <= '0;
            full     <= 1'b0;
        end else if (blk_release) begin
            beat_cnt <= '0;
            full     <= 1'b0;
        end else if (take) begin
            if (beat_cnt == CNT_W'(`ME_REF_BEATS - 1)) begin
                beat_cnt <= '0;
                full     <= 1'b1; // Window complete
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            for (int p = 0; p < PIX_PER_BEAT; p++) begin
                window[row][int'(grp) * PIX_PER_BEAT + p] <= ref_in[p*PIX_W +: PIX_W];
            end
        end
    end

endmodule

// ==== rtl/sad_array.sv ====
`include "me_defs.svh"

module sad_array (
    input  logic                                              clk,
    input  logic                                              rst,
    input  me_pkg::pixel_t [`ME_EDGE-1:0][`ME_EDGE-1:0]       cur_block,
    input  logic                                              cur_full,
    input  me_pkg::pixel_t [`ME_EDGE-1:0][`ME_WIN_COLS-1:0]   window,
    input  logic                                              ref_full,
    output logic                                              blk_release,
    psad_if.src                                               psad_o
);

    localparam me_pkg::cand_idx_t LAST_CAND = me_pkg::cand_idx_t'(`ME_CANDIDATES - 1);

    me_pkg::scan_state_t              state;
    me_pkg::cand_idx_t                cand; // Candidate scored this cycle
    logic                             issue;
    me_pkg::psad_t [`ME_EDGE-1:0]     row_sum;

    // Candidate 0 goes out on the first edge both buffers are full
    assign issue       = (state == me_pkg::scan_run) || (cur_full && ref_full);
    assign blk_release = issue && (cand == LAST_CAND);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= me_pkg::scan_idle;
            cand  <= '0;
        end else begin
            case (state)
                me_pkg::scan_idle: begin
                    if (issue) begin
                        state <= me_pkg::scan_run;
                        cand  <= cand + 1'b1;
                    end
                end
                me_pkg::scan_run: begin
                    if (cand == LAST_CAND) begin
                        state <= me_pkg::scan_idle;
                    end
                    cand <= cand + 1'b1; // Wraps back to 0 after the last one
                end
                default: begin
                    state <= me_pkg::scan_idle;
                    cand  <= '0;
                end
            endcase
        end
    end

    // 64 absolute differences folded into eight row sums
    always_comb begin
        me_pkg::pixel_t a;
        me_pkg::pixel_t b;
        me_pkg::pixel_t ad;
        for (int r = 0; r < `ME_EDGE; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < `ME_EDGE; c++) begin
                a          = cur_block[r][c];
                b          = window[r][int'(cand) + c];
                ad         = (a > b) ? a - b : b - a;
                row_sum[r] = row_sum[r] + me_pkg::psad_t'(ad);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            psad_o.valid <= 1'b0;
            psad_o.last  <= 1'b0;
        end else begin
            psad_o.valid <= issue;
            psad_o.last  <= blk_release; // Marks candidate 15
        end
    end

    always_ff @(posedge clk) begin
        psad_o.index <= cand;
        psad_o.psad  <= row_sum;
    end

endmodule

// ==== rtl/sad_adder.sv ====
`include "me_defs.svh"

module sad_adder (
    input  logic clk,
    input  logic rst,
    psad_if.dst  psad_i,
    sad_if.src   sad_o
);

    me_pkg::sad_t total;

    // Zero extend each row sum before adding
    always_comb begin
        total = '0;
        for (int r = 0; r < `ME_EDGE; r++) begin
            total = total + me_pkg::sad_t'(psad_i.psad[r]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sad_o.valid <= 1'b0;
            sad_o.last  <= 1'b0;
        end else begin
            sad_o.valid <= psad_i.valid;
            sad_o.last  <= psad_i.valid && psad_i.last;
        end
    end

    always_ff @(posedge clk) begin
        sad_o.index <= psad_i.index;
        sad_o.sad   <= total;
    end

endmodule

// ==== rtl/min_select.sv ====
module min_select (
    input  logic              clk,
    input  logic              rst,
    sad_if.dst                sad_i,
    output logic              result_valid,
    output me_pkg::sad_t      msad,
    output me_pkg::cand_idx_t mv_index
);

    me_pkg::sad_t      min_sad; // Best so far in this block
    me_pkg::cand_idx_t min_idx;
    logic              take_new;
    me_pkg::sad_t      best_sad;
    me_pkg::cand_idx_t best_idx;

    // Strictly smaller only, so the lower index keeps a tie
    assign take_new = (sad_i.index == '0) || (sad_i.sad < min_sad);
    assign best_sad = take_new ? sad_i.sad : min_sad;
    assign best_idx = take_new ? sad_i.index : min_idx;

    always_ff @(posedge clk) begin
        if (sad_i.valid) begin
            min_sad <= best_sad;
            min_idx <= best_idx;
        end
        if (sad_i.valid && sad_i.last) begin
            msad     <= best_sad; // Includes candidate 15 itself
            mv_index <= best_idx;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= sad_i.valid && sad_i.last;
        end
    end

endmodule

// ==== rtl/me_top.sv ====
`include "me_defs.svh"

module me_top (
    input  logic              clk,
    input  logic              rst,
    input  me_pkg::cur_beat_t cur_in,    // Four pixels
    input  logic              cur_valid,
    input  me_pkg::ref_beat_t ref_in,    // Eight pixels
    input  logic              ref_valid,
    output logic              need_cur,
    output logic              need_ref,
    output logic              result_valid,
    output me_pkg::sad_t      msad,
    output me_pkg::cand_idx_t mv_index
);

    me_pkg::pixel_t [`ME_EDGE-1:0][`ME_EDGE-1:0]     cur_block;
    me_pkg::pixel_t [`ME_EDGE-1:0][`ME_WIN_COLS-1:0] window;
    logic                                            cur_full;
    logic                                            ref_full;
    logic                                            blk_release; // Frees both buffers

    psad_if psad_bus ();
    sad_if  sad_bus ();

    cur_buffer i_cur_buffer (
        .clk         (clk),
        .rst         (rst),
        .cur_in      (cur_in),
        .cur_valid   (cur_valid),
        .blk_release (blk_release),
        .need_cur    (need_cur),
        .full        (cur_full),
        .cur_block   (cur_block)
    );

    ref_window i_ref_window (
        .clk         (clk),
        .rst         (rst),
        .ref_in      (ref_in),
        .ref_valid   (ref_valid),
        .blk_release (blk_release),
        .need_ref    (need_ref),
        .full        (ref_full),
        .window      (window)
    );

    sad_array i_sad_array (
        .clk         (clk),
        .rst         (rst),
        .cur_block   (cur_block),
        .cur_full    (cur_full),
        .window      (window),
        .ref_full    (ref_full),
        .blk_release (blk_release),
        .psad_o      (psad_bus.src)
    );

    sad_adder i_sad_adder (
        .clk    (clk),
        .rst    (rst),
        .psad_i (psad_bus.dst),
        .sad_o  (sad_bus.src)
    );

    min_select i_min_select (
        .clk          (clk),
        .rst          (rst),
        .sad_i        (sad_bus.dst),
        .result_valid (result_valid),
        .msad         (msad),
        .mv_index     (mv_index)
    );

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk; // Rising edges at odd half periods

endmodule

// ==== tests/me_top_asserts.sv ====
`include "me_defs.svh"

module me_top_asserts (
    input logic         clk,
    input logic         rst,
    input logic         need_cur,
    input logic         need_ref,
    input logic         result_valid,
    input me_pkg::sad_t msad
);

    localparam int MAX_SAD = `ME_EDGE * `ME_EDGE * 255; // All 64 pixels at full difference

    int fail_cnt = 0; // Read by the testbench for its summary

    single_result_pulse: assert property (
        @(posedge clk) disable iff (rst) result_valid |=> !result_valid
    ) else begin
        fail_cnt++;
        $error("result_valid high on two consecutive cycles");
    end

    msad_in_range: assert property (
        @(posedge clk) disable iff (rst) result_valid |-> (int'(msad) <= MAX_SAD)
    ) else begin
        fail_cnt++;
        $error("msad above the largest possible SAD");
    end

    // Both buffers ask for data right after reset
    need_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> (need_cur && need_ref)
    ) else begin
        fail_cnt++;
        $error("need_cur or need_ref low one cycle after reset");
    end

endmodule

// ==== tests/me_top_tb.sv ====
`include "me_defs.svh"

module me_top_tb;

    localparam int PERIOD       = 100;
    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DLY    = 10; // Inputs change this long after the rising edge
    localparam int SAMPLE_DLY   = 50; // Outputs are read mid cycle
    localparam int LATENCY      = 18;
    localparam int NUM_TESTS    = 12;
    localparam int CUR_PIX      = 4;  // Pixels per current beat
    localparam int REF_PIX      = 8;

    // Pixel pattern modes
    localparam int M_RAND = 0;
    localparam int M_FLAT = 1;
    localparam int M_ZERO = 2;
    localparam int M_MAX  = 3;
    localparam int M_COPY = 4; // Window only, random with the block planted at a candidate

    typedef struct {
        string name;
        int    cur_mode;
        int    win_mode;
        int    plant;
        bit    gap;
    } test_t;

    logic              clk;
    logic              rst;
    me_pkg::cur_beat_t cur_in;
    logic              cur_valid;
    me_pkg::ref_beat_t ref_in;
    logic              ref_valid;
    logic              need_cur;
    logic              need_ref;
    logic              result_valid;
    me_pkg::sad_t      msad;
    me_pkg::cand_idx_t mv_index;

    test_t       tests [NUM_TESTS];
    logic [7:0]  cur_pix [`ME_EDGE][`ME_EDGE];
    logic [7:0]  win_pix [`ME_EDGE][`ME_WIN_COLS];
    string       exp_name_q [$];
    int          exp_sad_q [$];
    int          exp_idx_q [$];
    longint      cur_done_q [$]; // Edge times of final accepted beats
    longint      ref_done_q [$];
    int          val_errs;
    int          lat_errs;
    int          other_errs;
    int          checked;
    int          total_errs;

    tb_clock #(.PERIOD(PERIOD)) i_clock (.clk(clk));

    me_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .cur_in       (cur_in),
        .cur_valid    (cur_valid),
        .ref_in       (ref_in),
        .ref_valid    (ref_valid),
        .need_cur     (need_cur),
        .need_ref     (need_ref),
        .result_valid (result_valid),
        .msad         (msad),
        .mv_index     (mv_index)
    );

    bind me_top me_top_asserts i_asserts (
        .clk          (clk),
        .rst          (rst),
        .need_cur     (need_cur),
        .need_ref     (need_ref),
        .result_valid (result_valid),
        .msad         (msad)
    );

    function automatic void fill_table();
        tests[0]  = '{"exact_k0", M_RAND, M_COPY, 0, 1'b0};
        tests[1]  = '{"exact_k7", M_RAND, M_COPY, 7, 1'b0};
        tests[2]  = '{"exact_k15", M_RAND, M_COPY, 15, 1'b0};
        tests[3]  = '{"tie_flat", M_FLAT, M_FLAT, 0, 1'b0};
        tests[4]  = '{"saturate", M_ZERO, M_MAX, 0, 1'b0};
        tests[5]  = '{"random_a", M_RAND, M_RAND, 0, 1'b0};
        tests[6]  = '{"random_b", M_RAND, M_RAND, 0, 1'b0};
        tests[7]  = '{"exact_k11_gaps", M_RAND, M_COPY, 11, 1'b1};
        tests[8]  = '{"random_gaps", M_RAND, M_RAND, 0, 1'b1};
        tests[9]  = '{"tie_flat_gaps", M_FLAT, M_FLAT, 0, 1'b1};
        tests[10] = '{"saturate_gaps", M_ZERO, M_MAX, 0, 1'b1};
        tests[11] = '{"random_c", M_RAND, M_RAND, 0, 1'b0};
    endfunction

    function automatic logic [7:0] pick_pixel(int mode, logic [7:0] flat);
        case (mode)
            M_FLAT:  return flat;
            M_ZERO:  return 8'd0;
            M_MAX:   return 8'd255;
            default: return 8'($urandom);
        endcase
    endfunction

    task automatic build_pixels(test_t t);
        for (int r = 0; r < `ME_EDGE; r++) begin
            for (int c = 0; c < `ME_EDGE; c++) begin
                cur_pix[r][c] = pick_pixel(t.cur_mode, 8'd100);
            end
            for (int c = 0; c < `ME_WIN_COLS; c++) begin
                win_pix[r][c] = pick_pixel(t.win_mode, 8'd37);
            end
            if (t.win_mode == M_COPY) begin
                for (int c = 0; c < `ME_EDGE; c++) begin
                    win_pix[r][t.plant + c] = cur_pix[r][c];
                end
            end
        end
    endtask

    // Scores every candidate, first strict minimum wins
    task automatic model_best(output int best_sad, output int best_idx);
        int sad;
        int a;
        int b;
        best_sad = -1;
        best_idx = 0;
        for (int k = 0; k < `ME_CANDIDATES; k++) begin
            sad = 0;
            for (int r = 0; r < `ME_EDGE; r++) begin
                for (int c = 0; c < `ME_EDGE; c++) begin
                    a = cur_pix[r][c];
                    b = win_pix[r][k + c];
                    sad += (a > b) ? a - b : b - a;
                end
            end
            if (best_sad < 0 || sad < best_sad) begin
                best_sad = sad;
                best_idx = k;
            end
        end
    endtask

    function automatic me_pkg::cur_beat_t cur_beat(int n);
        me_pkg::cur_beat_t beat;
        for (int p = 0; p < CUR_PIX; p++) begin
            beat[p*8 +: 8] = cur_pix[n / 2][CUR_PIX * (n % 2) + p];
        end
        return beat;
    endfunction

    function automatic me_pkg::ref_beat_t ref_beat(int m);
        me_pkg::ref_beat_t beat;
        for (int p = 0; p < REF_PIX; p++) begin
            beat[p*8 +: 8] = win_pix[m / 3][REF_PIX * (m % 3) + p];
        end
        return beat;
    endfunction

    // Called at a drive point, returns at one with valid still high
    task automatic send_cur(bit gap);
        int n;
        bit go;
        bit taken;
        n = 0;
        while (n < `ME_CUR_BEATS) begin
            go        = !gap || ($urandom % 3 != 0);
            cur_valid = go;
            cur_in    = go ? cur_beat(n) : me_pkg::cur_beat_t'($urandom);
            taken     = go && need_cur; // need only moves on an edge
            @(posedge clk);
            #DRIVE_DLY;
            if (taken) begin
                n++;
                if (n == `ME_CUR_BEATS) begin
                    cur_done_q.push_back($time - DRIVE_DLY);
                end
            end
        end
    endtask

    task automatic send_ref(bit gap);
        int m;
        bit go;
        bit taken;
        m = 0;
        while (m < `ME_REF_BEATS) begin
            go        = !gap || ($urandom % 3 != 0);
            ref_valid = go;
            ref_in    = go ? ref_beat(m) : {2{32'($urandom)}};
            taken     = go && need_ref;
            @(posedge clk);
            #DRIVE_DLY;
            if (taken) begin
                m++;
                if (m == `ME_REF_BEATS) begin
                    ref_done_q.push_back($time - DRIVE_DLY);
                end
            end
        end
    endtask

    task automatic check_result();
        string  name;
        int     exp_sad;
        int     exp_idx;
        longint done_t;
        longint lat;
        if (exp_name_q.size() == 0) begin
            $display("result_valid pulsed with no block outstanding at time %0t", $time);
            other_errs++;
            return;
        end
        name    = exp_name_q.pop_front();
        exp_sad = exp_sad_q.pop_front();
        exp_idx = exp_idx_q.pop_front();
        if (msad !== me_pkg::sad_t'(exp_sad)) begin
            $display("error %s: msad expected %0d actual %0d", name, exp_sad, msad);
            val_errs++;
        end
        if (mv_index !== me_pkg::cand_idx_t'(exp_idx)) begin
            $display("error %s: mv_index expected %0d actual %0d", name, exp_idx, mv_index);
            val_errs++;
        end
        if (cur_done_q.size() == 0 || ref_done_q.size() == 0) begin
            $display("%s: result came before both final beats were accepted", name);
            other_errs++;
        end else begin
            done_t = cur_done_q.pop_front();
            if (ref_done_q[0] > done_t) begin
                done_t = ref_done_q[0];
            end
            void'(ref_done_q.pop_front());
            lat = ($time - SAMPLE_DLY - done_t) / PERIOD;
            if (lat != LATENCY) begin
                $display("error %s: latency expected %0d actual %0d", name, LATENCY, lat);
                lat_errs++;
            end
        end
        checked++;
    endtask

    task automatic report_counts();
        $display("summary: %0d/%0d checked, errors %0d value %0d latency %0d other %0d assert",
                 checked, NUM_TESTS, val_errs, lat_errs, other_errs,
                 i_dut.i_asserts.fail_cnt);
    endtask

    always begin
        @(posedge clk);
        #SAMPLE_DLY;
        if (result_valid === 1'b1) begin
            check_result();
        end
    end

    initial begin : watchdog
        #(longint'(NUM_TESTS) * 100 * PERIOD + RESET_CYCLES * PERIOD);
        $display("timeout: result_valid never came for %0d of %0d tests",
                 NUM_TESTS - checked, NUM_TESTS);
        report_counts();
        $display("Something failed");
        $finish;
    end

    initial begin
        int exp_sad;
        int exp_idx;
        rst        = 1'b1;
        cur_in     = '0;
        cur_valid  = 1'b0;
        ref_in     = '0;
        ref_valid  = 1'b0;
        val_errs   = 0;
        lat_errs   = 0;
        other_errs = 0;
        checked    = 0;
        void'($urandom(56201)); // One seed for the whole run
        fill_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(posedge clk);
        #SAMPLE_DLY;
        if (need_cur !== 1'b1) begin
            $display("error reset_defaults: need_cur expected 1 actual %b", need_cur);
            val_errs++;
        end
        if (need_ref !== 1'b1) begin
            $display("error reset_defaults: need_ref expected 1 actual %b", need_ref);
            val_errs++;
        end
        if (result_valid !== 1'b0) begin
            $display("error reset_defaults: result_valid expected 0 actual %b", result_valid);
            val_errs++;
        end

        @(posedge clk);
        #DRIVE_DLY;
        // Entries go back to back, the next block waits on need
        for (int i = 0; i < NUM_TESTS; i++) begin
            build_pixels(tests[i]);
            model_best(exp_sad, exp_idx);
            exp_name_q.push_back(tests[i].name);
            exp_sad_q.push_back(exp_sad);
            exp_idx_q.push_back(exp_idx);
            fork
                send_cur(tests[i].gap);
                send_ref(tests[i].gap);
            join
        end
        cur_valid = 1'b0;
        ref_valid = 1'b0;

        wait (checked == NUM_TESTS);
        repeat (LATENCY + 4) @(posedge clk); // Catch any stray extra pulse
        report_counts();
        total_errs = val_errs + lat_errs + other_errs + i_dut.i_asserts.fail_cnt;
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== me_top.f ====
+incdir+rtl
rtl/me_pkg.sv
rtl/me_ifs.sv
rtl/cur_buffer.sv
rtl/ref_window.sv
rtl/sad_array.sv
rtl/sad_adder.sv
rtl/min_select.sv
rtl/me_top.sv
tests/tb_clock.sv
tests/me_top_asserts.sv
tests/me_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= me_top_tb
LINT_TOP  ?= me_top
FILELIST  ?= me_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)
	@echo "simulation passed, log in $(LOG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
